// File: src/mcoi_app_pkg.sv
// widths, buffer ids, readback pages, reader states and fixed constants of the receive-clock application
package mcoi_app_pkg;

   // ----------------------------------------------------------------------
   // motor words
   // ----------------------------------------------------------------------
   // motors served by one fiber
   localparam int NUM_MOTORS   = 16;
   localparam int MOTOR_IDX_W  = 4;
   // control bits per motor: 0 step clock, 1 deactivate, 2 direction, 3 boost
   // status bits per motor: 0 fail, 1 switch A, 2 switch B, 3 overheat
   localparam int MOTOR_BITS   = 4;
   localparam int MOTOR_WORD_W = NUM_MOTORS * MOTOR_BITS;

   // ----------------------------------------------------------------------
   // processor buffer
   // ----------------------------------------------------------------------
   localparam int BUF_DEPTH  = 16;
   localparam int BUF_ADDR_W = 4;
   // word layout: id in 31..24, reserved 23..16, value in 15..0
   localparam int BUF_DATA_W = 32;
   localparam int ID_W       = 8;
   localparam int VALUE_W    = 16;

   // entry ids, unique id slices go lowest first
   localparam logic [ID_W-1:0] ID_UID0        = 8'd1;
   localparam logic [ID_W-1:0] ID_UID1        = 8'd2;
   localparam logic [ID_W-1:0] ID_UID2        = 8'd4;
   localparam logic [ID_W-1:0] ID_UID3        = 8'd5;
   localparam logic [ID_W-1:0] ID_POWER       = 8'd10;
   localparam logic [ID_W-1:0] ID_TEMPERATURE = 8'd13;

   localparam int UID_W = 64;

   // reader FSM encoding
   localparam int               STATE_W     = 2;
   localparam logic [STATE_W-1:0] ST_WAIT     = 2'd0;
   localparam logic [STATE_W-1:0] ST_READ     = 2'd1;
   localparam logic [STATE_W-1:0] ST_FINISHED = 2'd2;

   // ----------------------------------------------------------------------
   // readback
   // ----------------------------------------------------------------------
   localparam int WORD_W   = 32;
   localparam int PAGE_W   = 8;
   localparam int PCBREV_W = 4;

   localparam logic [PAGE_W-1:0] PAGE_LOOPBACK    = 8'd0;
   localparam logic [PAGE_W-1:0] PAGE_BUILD       = 8'd1;
   localparam logic [PAGE_W-1:0] PAGE_PCBREV      = 8'd2;
   localparam logic [PAGE_W-1:0] PAGE_UID_HI      = 8'd3;
   localparam logic [PAGE_W-1:0] PAGE_UID_LO      = 8'd4;
   localparam logic [PAGE_W-1:0] PAGE_TEMPERATURE = 8'd5;
   localparam logic [PAGE_W-1:0] PAGE_POWER       = 8'd6;
   localparam logic [PAGE_W-1:0] PAGE_ONE         = 8'd7;
   // motor m answers on page PAGE_MOTOR_BASE + m
   localparam logic [PAGE_W-1:0] PAGE_MOTOR_BASE  = 8'd16;

   localparam logic [WORD_W-1:0] READBACK_DEFAULT = 32'hdead_beef;
   localparam logic [WORD_W-1:0] GEFE_INTERLOCK   = 32'h4745_4645;
   localparam logic [WORD_W-1:0] BUILD_NUMBER     = 32'h2022_0220;

   // flip-flops behind the driver status pins
   localparam int SYNC_STAGES = 3;

endpackage

// File: src/ps_buffer_reader.sv
// req/ack FSM that sweeps the processor buffer and registers id/value entries
`timescale 1ns/1ps

module ps_buffer_reader import mcoi_app_pkg::*; (
   input  logic                  gbt_rx_clkrs,
   input  logic                  rst_i,
   input  logic                  ps_req_i,
   input  logic [BUF_DATA_W-1:0] buf_data_i,
   output logic                  ps_ack_o,
   output logic [BUF_ADDR_W-1:0] buf_addr_o,
   output logic                  entry_valid_o,
   output logic [ID_W-1:0]       entry_id_o,
   output logic [VALUE_W-1:0]    entry_value_o
);

   logic [STATE_W-1:0] state_q;
   // last address issued, then two drain cycles
   logic               sweep_done_q;
   logic               drain_q;
   // data on buf_data_i belongs to an issued address
   logic               mem_valid_q;

   // ----------------------------------------------------------------------
   // handshake and address sweep
   // ----------------------------------------------------------------------
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         state_q      <= ST_WAIT;
         ps_ack_o     <= 1'b0;
         buf_addr_o   <= '0;
         sweep_done_q <= 1'b0;
         drain_q      <= 1'b0;
      end else begin
         case (state_q)
            ST_WAIT: begin
               // stay here until the processor asks
               if (ps_req_i) begin
                  ps_ack_o     <= 1'b1;
                  buf_addr_o   <= '0;
                  sweep_done_q <= 1'b0;
                  drain_q      <= 1'b0;
                  state_q      <= ST_READ;
               end
            end
            ST_READ: begin
               if (!sweep_done_q) begin
                  if (buf_addr_o == BUF_ADDR_W'(BUF_DEPTH - 1)) begin
                     sweep_done_q <= 1'b1;
                  end else begin
                     buf_addr_o <= buf_addr_o + BUF_ADDR_W'(1);
                  end
               end else if (!drain_q) begin
                  drain_q <= 1'b1;
               end else begin
                  // last entry is out, wait for request release
                  state_q <= ST_FINISHED;
               end
            end
            ST_FINISHED: begin
               if (!ps_req_i) begin
                  ps_ack_o   <= 1'b0;
                  buf_addr_o <= '0;
                  state_q    <= ST_WAIT;
               end
            end
            default: begin
               ps_ack_o <= 1'b0;
               state_q  <= ST_WAIT;
            end
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // entry capture, one cycle behind the memory
   // ----------------------------------------------------------------------
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         mem_valid_q   <= 1'b0;
         entry_valid_o <= 1'b0;
      end else begin
         mem_valid_q   <= (state_q == ST_READ) && !sweep_done_q;
         entry_valid_o <= mem_valid_q;
      end
   end

   always_ff @(posedge gbt_rx_clkrs) begin
      entry_id_o    <= buf_data_i[BUF_DATA_W-1 -: ID_W];
      entry_value_o <= buf_data_i[VALUE_W-1:0];
   end

endmodule

// File: src/ps_register_file.sv
// entry id demultiplexer into unique-id, power and temperature registers with shadow copy
`timescale 1ns/1ps

module ps_register_file import mcoi_app_pkg::*; (
   input  logic               gbt_rx_clkrs,
   input  logic               rst_i,
   input  logic               entry_valid_i,
   input  logic [ID_W-1:0]    entry_id_i,
   input  logic [VALUE_W-1:0] entry_value_i,
   input  logic               transfer_busy_i,
   output logic [UID_W-1:0]   uid_o,
   output logic [WORD_W-1:0]  power_o,
   output logic [WORD_W-1:0]  temperature_o
);

   // working copies, filled during a transfer
   logic [UID_W-1:0]   uid_q;
   logic [VALUE_W-1:0] power_q;
   logic [VALUE_W-1:0] temperature_q;

   // ----------------------------------------------------------------------
   // demultiplexer
   // ----------------------------------------------------------------------
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         uid_q         <= '0;
         power_q       <= '0;
         temperature_q <= '0;
      end else if (entry_valid_i) begin
         case (entry_id_i)
            ID_UID0:        uid_q[0*VALUE_W +: VALUE_W] <= entry_value_i;
            ID_UID1:        uid_q[1*VALUE_W +: VALUE_W] <= entry_value_i;
            ID_UID2:        uid_q[2*VALUE_W +: VALUE_W] <= entry_value_i;
            ID_UID3:        uid_q[3*VALUE_W +: VALUE_W] <= entry_value_i;
            ID_POWER:       power_q       <= entry_value_i;
            ID_TEMPERATURE: temperature_q <= entry_value_i;
            // unknown ids leave everything alone
            default: ;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // shadow copy seen by the readback side
   // ----------------------------------------------------------------------
   // frozen while the processor owns the transfer, so a half written
   // unique id never reaches the link
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         uid_o         <= '0;
         power_o       <= '0;
         temperature_o <= '0;
      end else if (!transfer_busy_i) begin
         uid_o         <= uid_q;
         // zero extension to the readback width
         power_o       <= WORD_W'(power_q);
         temperature_o <= WORD_W'(temperature_q);
      end
   end

endmodule

// File: src/motor_interlock.sv
// interlock check on the feedback word and registered motor control pin mapping
`timescale 1ns/1ps

module motor_interlock import mcoi_app_pkg::*; (
   input  logic                    gbt_rx_clkrs,
   input  logic                    rst_i,
   input  logic [MOTOR_WORD_W-1:0] rx_data_i,
   input  logic [WORD_W-1:0]       feedback_i,
   output logic [NUM_MOTORS-1:0]   pl_clk_o,
   output logic [NUM_MOTORS-1:0]   pl_en_o,
   output logic [NUM_MOTORS-1:0]   pl_dir_o,
   output logic [NUM_MOTORS-1:0]   pl_boost_o
);

   logic [MOTOR_WORD_W-1:0] control_q;

   // all ones sets deactivate on every motor
   // link not closed means motors stay off
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         control_q <= '1;
      end else if (feedback_i == GEFE_INTERLOCK) begin
         control_q <= rx_data_i;
      end else begin
         control_q <= '1;
      end
   end

   // ----------------------------------------------------------------------
   // pin mapping, four bits per motor
   // ----------------------------------------------------------------------
   for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_pins
      assign pl_clk_o[m]   = control_q[m*MOTOR_BITS + 0];
      // driver enable pin is really a deactivate
      assign pl_en_o[m]    = control_q[m*MOTOR_BITS + 1];
      assign pl_dir_o[m]   = control_q[m*MOTOR_BITS + 2];
      assign pl_boost_o[m] = control_q[m*MOTOR_BITS + 3];
   end

endmodule

// File: src/status_synchronizer.sv
// inversion, packing and three-stage synchronization of the motor driver status pins
`timescale 1ns/1ps

module status_synchronizer import mcoi_app_pkg::*; (
   input  logic                    gbt_rx_clkrs,
   input  logic                    rst_i,
   input  logic [NUM_MOTORS-1:0]   pl_pfail_i,
   input  logic [NUM_MOTORS-1:0]   pl_sw_outa_i,
   input  logic [NUM_MOTORS-1:0]   pl_sw_outb_i,
   output logic [MOTOR_WORD_W-1:0] motor_status_o
);

   logic [MOTOR_WORD_W-1:0]                  status_raw;
   logic [SYNC_STAGES-1:0][MOTOR_WORD_W-1:0] sync_q;

   // pins are active low, status word is active high
   for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_pack
      assign status_raw[m*MOTOR_BITS + 0] = ~pl_pfail_i[m];
      assign status_raw[m*MOTOR_BITS + 1] = ~pl_sw_outa_i[m];
      assign status_raw[m*MOTOR_BITS + 2] = ~pl_sw_outb_i[m];
      // overheat not wired on this board
      assign status_raw[m*MOTOR_BITS + 3] = 1'b0;
   end

   // ----------------------------------------------------------------------
   // synchronizer chain, pins are asynchronous to the link clock
   // ----------------------------------------------------------------------
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], status_raw};
      end
   end

   assign motor_status_o = sync_q[SYNC_STAGES-1];

endmodule

// File: src/readback_mux.sv
// loopback register and page-selected registered readback word
`timescale 1ns/1ps

module readback_mux import mcoi_app_pkg::*; (
   input  logic                    gbt_rx_clkrs,
   input  logic                    rst_i,
   input  logic [WORD_W-1:0]       page_select_i,
   input  logic                    page_update_i,
   input  logic                    rx_clken_i,
   input  logic [PCBREV_W-1:0]     pcbrev_i,
   input  logic [UID_W-1:0]        uid_i,
   input  logic [WORD_W-1:0]       power_i,
   input  logic [WORD_W-1:0]       temperature_i,
   input  logic [MOTOR_WORD_W-1:0] motor_status_i,
   output logic [WORD_W-1:0]       readback_o
);

   logic [WORD_W-1:0]      loopback_q;
   logic [PAGE_W-1:0]      page;
   logic [PAGE_W-1:0]      motor_offset;
   logic                   motor_page;
   logic [MOTOR_IDX_W-1:0] motor_idx;

   // ----------------------------------------------------------------------
   // loopback word
   // ----------------------------------------------------------------------
   // bit 31 echoes the selector, bit 0 always set so the far end sees life
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         loopback_q <= WORD_W'(1);
      end else if (page_update_i) begin
         loopback_q <= {page_select_i[WORD_W-1], {(WORD_W-2){1'b0}}, 1'b1};
      end
   end

   // ----------------------------------------------------------------------
   // page decode
   // ----------------------------------------------------------------------
   assign page         = page_select_i[PAGE_W-1:0];
   assign motor_offset = page - PAGE_MOTOR_BASE;
   // wraps below the base, so one compare covers the whole motor range
   assign motor_page   = motor_offset < PAGE_W'(NUM_MOTORS);
   assign motor_idx    = motor_offset[MOTOR_IDX_W-1:0];

   // word only moves on link clock enable
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         readback_o <= '0;
      end else if (rx_clken_i) begin
         case (page)
            PAGE_LOOPBACK:    readback_o <= loopback_q;
            PAGE_BUILD:       readback_o <= BUILD_NUMBER;
            PAGE_PCBREV:      readback_o <= WORD_W'(pcbrev_i);
            PAGE_UID_HI:      readback_o <= uid_i[UID_W-1 -: WORD_W];
            PAGE_UID_LO:      readback_o <= uid_i[WORD_W-1:0];
            PAGE_TEMPERATURE: readback_o <= temperature_i;
            PAGE_POWER:       readback_o <= power_i;
            PAGE_ONE:         readback_o <= WORD_W'(1);
            default: begin
               if (motor_page) begin
                  // 4-bit status field of one motor
                  readback_o <= WORD_W'(motor_status_i[motor_idx*MOTOR_BITS +: MOTOR_BITS]);
               end else begin
                  readback_o <= READBACK_DEFAULT;
               end
            end
         endcase
      end
   end

endmodule

// File: src/mcoi_app_top.sv
// top level wiring of the receive-clock blocks of the motor controller application
`timescale 1ns/1ps

module mcoi_app_top import mcoi_app_pkg::*; (
   input  logic                    gbt_rx_clkrs,
   input  logic                    rst_i,
   // processor buffer and handshake
   input  logic                    ps_req_i,
   input  logic [BUF_DATA_W-1:0]   buf_data_i,
   output logic                    ps_ack_o,
   output logic [BUF_ADDR_W-1:0]   buf_addr_o,
   // link side
   input  logic [MOTOR_WORD_W-1:0] rx_data_i,
   input  logic [WORD_W-1:0]       feedback_i,
   input  logic [WORD_W-1:0]       page_select_i,
   input  logic                    page_update_i,
   input  logic                    rx_clken_i,
   input  logic [PCBREV_W-1:0]     pcbrev_i,
   output logic [MOTOR_WORD_W-1:0] motor_data_o,
   output logic [WORD_W-1:0]       readback_o,
   // motor driver pins
   input  logic [NUM_MOTORS-1:0]   pl_pfail_i,
   input  logic [NUM_MOTORS-1:0]   pl_sw_outa_i,
   input  logic [NUM_MOTORS-1:0]   pl_sw_outb_i,
   output logic [NUM_MOTORS-1:0]   pl_clk_o,
   output logic [NUM_MOTORS-1:0]   pl_en_o,
   output logic [NUM_MOTORS-1:0]   pl_dir_o,
   output logic [NUM_MOTORS-1:0]   pl_boost_o
);

   logic                    entry_valid;
   logic [ID_W-1:0]         entry_id;
   logic [VALUE_W-1:0]      entry_value;
   logic [UID_W-1:0]        uid_shadow;
   logic [WORD_W-1:0]       power_shadow;
   logic [WORD_W-1:0]       temperature_shadow;
   logic [MOTOR_WORD_W-1:0] motor_status;

   // ----------------------------------------------------------------------
   // processor side, acknowledge doubles as transfer busy
   // ----------------------------------------------------------------------
   ps_buffer_reader ps_buffer_reader_inst (
      .gbt_rx_clkrs  (gbt_rx_clkrs),
      .rst_i         (rst_i),
      .ps_req_i      (ps_req_i),
      .buf_data_i    (buf_data_i),
      .ps_ack_o      (ps_ack_o),
      .buf_addr_o    (buf_addr_o),
      .entry_valid_o (entry_valid),
      .entry_id_o    (entry_id),
      .entry_value_o (entry_value)
   );

   ps_register_file ps_register_file_inst (
      .gbt_rx_clkrs    (gbt_rx_clkrs),
      .rst_i           (rst_i),
      .entry_valid_i   (entry_valid),
      .entry_id_i      (entry_id),
      .entry_value_i   (entry_value),
      .transfer_busy_i (ps_ack_o),
      .uid_o           (uid_shadow),
      .power_o         (power_shadow),
      .temperature_o   (temperature_shadow)
   );

   // ----------------------------------------------------------------------
   // motor pins
   // ----------------------------------------------------------------------
   motor_interlock motor_interlock_inst (
      .gbt_rx_clkrs (gbt_rx_clkrs),
      .rst_i        (rst_i),
      .rx_data_i    (rx_data_i),
      .feedback_i   (feedback_i),
      .pl_clk_o     (pl_clk_o),
      .pl_en_o      (pl_en_o),
      .pl_dir_o     (pl_dir_o),
      .pl_boost_o   (pl_boost_o)
   );

   status_synchronizer status_synchronizer_inst (
      .gbt_rx_clkrs   (gbt_rx_clkrs),
      .rst_i          (rst_i),
      .pl_pfail_i     (pl_pfail_i),
      .pl_sw_outa_i   (pl_sw_outa_i),
      .pl_sw_outb_i   (pl_sw_outb_i),
      .motor_status_o (motor_status)
   );

   // status goes back on the link as is
   assign motor_data_o = motor_status;

   // ----------------------------------------------------------------------
   // readback
   // ----------------------------------------------------------------------
   readback_mux readback_mux_inst (
      .gbt_rx_clkrs   (gbt_rx_clkrs),
      .rst_i          (rst_i),
      .page_select_i  (page_select_i),
      .page_update_i  (page_update_i),
      .rx_clken_i     (rx_clken_i),
      .pcbrev_i       (pcbrev_i),
      .uid_i          (uid_shadow),
      .power_i        (power_shadow),
      .temperature_i  (temperature_shadow),
      .motor_status_i (motor_status),
      .readback_o     (readback_o)
   );

endmodule

// File: verification/tb_mcoi_app.sv
// testbench for the receive-clock application: clock, reset, buffer model, reference models, checks
`timescale 1ns/1ps

module tb_mcoi_app import mcoi_app_pkg::*; ();

   localparam int RESET_CYC   = 8;
   localparam int N_INTERLOCK = 40;
   localparam int N_STATUS    = 6;
   localparam int N_TRANSFER  = 5;
   localparam int ACK_LIMIT   = 8;
   // test lengths in clock cycles, the watchdog allows twice their sum
   localparam int CYC_RESET     = RESET_CYC + 4;
   localparam int CYC_INTERLOCK = N_INTERLOCK * 2 + 2;
   localparam int CYC_STATUS    = N_STATUS * (6 + NUM_MOTORS * 2);
   localparam int CYC_TRANSFER  = N_TRANSFER * (ACK_LIMIT * 2 + BUF_DEPTH + 4 + 20);
   localparam int CYC_READBACK  = 30;
   localparam int WATCHDOG_NS   =
      2 * 10 * (CYC_RESET + CYC_INTERLOCK + CYC_STATUS + CYC_TRANSFER + CYC_READBACK);

   logic                    gbt_rx_clkrs;
   logic                    rst_i;
   logic                    ps_req_i;
   logic [BUF_DATA_W-1:0]   buf_data_i;
   logic                    ps_ack_o;
   logic [BUF_ADDR_W-1:0]   buf_addr_o;
   logic [MOTOR_WORD_W-1:0] rx_data_i;
   logic [WORD_W-1:0]       feedback_i;
   logic [WORD_W-1:0]       page_select_i;
   logic                    page_update_i;
   logic                    rx_clken_i;
   logic [PCBREV_W-1:0]     pcbrev_i;
   logic [MOTOR_WORD_W-1:0] motor_data_o;
   logic [WORD_W-1:0]       readback_o;
   logic [NUM_MOTORS-1:0]   pl_pfail_i;
   logic [NUM_MOTORS-1:0]   pl_sw_outa_i;
   logic [NUM_MOTORS-1:0]   pl_sw_outb_i;
   logic [NUM_MOTORS-1:0]   pl_clk_o;
   logic [NUM_MOTORS-1:0]   pl_en_o;
   logic [NUM_MOTORS-1:0]   pl_dir_o;
   logic [NUM_MOTORS-1:0]   pl_boost_o;

   // buffer memory and reference state of the diagnostic registers
   logic [BUF_DATA_W-1:0] buf_mem [BUF_DEPTH];
   logic [BUF_ADDR_W-1:0] rd_addr_q;
   logic [UID_W-1:0]      uid_m;
   logic [VALUE_W-1:0]    power_m;
   logic [VALUE_W-1:0]    temp_m;
   logic [ID_W-1:0]       known_ids [6] = '{ID_UID0, ID_UID1, ID_UID2, ID_UID3,
                                            ID_POWER, ID_TEMPERATURE};

   int errors;
   int err_at_start;
   int tests_done;
   int tests_failed;

   mcoi_app_top mcoi_app_top_inst (.*);

   always #5 gbt_rx_clkrs = ~gbt_rx_clkrs;

   // synchronous read: address latched on the rising edge, data out half a cycle later
   always @(posedge gbt_rx_clkrs) rd_addr_q <= buf_addr_o;
   always @(negedge gbt_rx_clkrs) buf_data_i = buf_mem[rd_addr_q];

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("FAIL: see errors above");
      $finish;
   end

   // ----------------------------------------------------------------------
   // reference models and reporting
   // ----------------------------------------------------------------------
   // order per motor: step clock, deactivate, direction, boost
   function automatic logic [MOTOR_WORD_W-1:0] pack_pins(input logic [NUM_MOTORS-1:0] c,
      input logic [NUM_MOTORS-1:0] e, input logic [NUM_MOTORS-1:0] d,
      input logic [NUM_MOTORS-1:0] b);
      logic [MOTOR_WORD_W-1:0] w;
      for (int m = 0; m < NUM_MOTORS; m++) begin
         w[m*MOTOR_BITS +: MOTOR_BITS] = {b[m], d[m], e[m], c[m]};
      end
      return w;
   endfunction

   // inverted fail, switch A, switch B, overheat at zero
   function automatic logic [MOTOR_WORD_W-1:0] expected_status(
      input logic [NUM_MOTORS-1:0] f, input logic [NUM_MOTORS-1:0] a,
      input logic [NUM_MOTORS-1:0] b);
      logic [MOTOR_WORD_W-1:0] w;
      for (int m = 0; m < NUM_MOTORS; m++) begin
         w[m*MOTOR_BITS +: MOTOR_BITS] = {1'b0, ~b[m], ~a[m], ~f[m]};
      end
      return w;
   endfunction

   function automatic bit is_known_id(input logic [ID_W-1:0] id);
      for (int i = 0; i < 6; i++) begin
         if (known_ids[i] == id) return 1'b1;
      end
      return 1'b0;
   endfunction

   // last entry of each id in address order wins
   task automatic apply_entries();
      logic [ID_W-1:0]    id;
      logic [VALUE_W-1:0] v;
      for (int a = 0; a < BUF_DEPTH; a++) begin
         id = buf_mem[a][31:24];
         v  = buf_mem[a][15:0];
         if (id == ID_UID0) uid_m[15:0] = v;
         else if (id == ID_UID1) uid_m[31:16] = v;
         else if (id == ID_UID2) uid_m[47:32] = v;
         else if (id == ID_UID3) uid_m[63:48] = v;
         else if (id == ID_POWER) power_m = v;
         else if (id == ID_TEMPERATURE) temp_m = v;
      end
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp,
      input logic [63:0] act);
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("ERROR %s", msg);
      errors++;
   endtask

   task automatic end_test(input string name);
      tests_done++;
      if (errors > err_at_start) begin
         tests_failed++;
         $display("test %s finished with %0d errors", name, errors - err_at_start);
      end else begin
         $display("test %s finished ok", name);
      end
      err_at_start = errors;
   endtask

   // called on a falling edge, returns on the next one
   task automatic read_page(input logic [PAGE_W-1:0] page, output logic [WORD_W-1:0] w);
      page_select_i = {24'($urandom), page};
      rx_clken_i    = 1'b1;
      @(negedge gbt_rx_clkrs);
      w = readback_o;
   endtask

   task automatic check_diag_pages(input string name);
      logic [WORD_W-1:0] w;
      read_page(PAGE_UID_HI, w);
      if (w !== uid_m[63:32]) report_mismatch({name, " uid_hi"}, 64'(uid_m[63:32]), 64'(w));
      read_page(PAGE_UID_LO, w);
      if (w !== uid_m[31:0]) report_mismatch({name, " uid_lo"}, 64'(uid_m[31:0]), 64'(w));
      read_page(PAGE_TEMPERATURE, w);
      if (w !== 32'(temp_m)) report_mismatch({name, " temperature"}, 64'(temp_m), 64'(w));
      read_page(PAGE_POWER, w);
      if (w !== 32'(power_m)) report_mismatch({name, " power"}, 64'(power_m), 64'(w));
   endtask

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------
   initial begin
      logic [WORD_W-1:0]       w;
      logic [WORD_W-1:0]       sel;
      logic [MOTOR_WORD_W-1:0] exp_w;
      logic [ID_W-1:0]         id;
      logic [PAGE_W-1:0]       p;
      int                      n;
      int unsigned             seed;
      seed          = $urandom(45995);
      errors        = 0;
      err_at_start  = 0;
      tests_done    = 0;
      tests_failed  = 0;
      gbt_rx_clkrs  = 1'b0;
      rst_i         = 1'b1;
      ps_req_i      = 1'b0;
      buf_data_i    = '0;
      rx_data_i     = '0;
      feedback_i    = '0;
      page_select_i = '0;
      page_update_i = 1'b0;
      rx_clken_i    = 1'b0;
      pcbrev_i      = '0;
      // driver status pins idle high
      pl_pfail_i    = '1;
      pl_sw_outa_i  = '1;
      pl_sw_outb_i  = '1;
      uid_m         = '0;
      power_m       = '0;
      temp_m        = '0;
      for (int i = 0; i < BUF_DEPTH; i++) begin
         buf_mem[i] = {8'hee, 20'h0, 4'(i)};
      end
      repeat (RESET_CYC) @(negedge gbt_rx_clkrs);
      rst_i = 1'b0;

      // reset values
      if (ps_ack_o !== 1'b0) report_mismatch("reset ack", 64'd0, 64'(ps_ack_o));
      if (buf_addr_o !== '0) report_mismatch("reset addr", 64'd0, 64'(buf_addr_o));
      exp_w = '1;
      if (pack_pins(pl_clk_o, pl_en_o, pl_dir_o, pl_boost_o) !== exp_w)
         report_mismatch("reset pins", exp_w, pack_pins(pl_clk_o, pl_en_o, pl_dir_o, pl_boost_o));
      if (readback_o !== '0) report_mismatch("reset readback", 64'd0, 64'(readback_o));
      if (motor_data_o !== '0) report_mismatch("reset motor_data", 64'd0, motor_data_o);
      read_page(PAGE_LOOPBACK, w);
      if (w !== 32'd1) report_mismatch("reset loopback", 64'd1, 64'(w));
      end_test("reset");

      // interlock, feedback matches about half the time
      for (int i = 0; i < N_INTERLOCK; i++) begin
         rx_data_i = {$urandom, $urandom};
         if ($urandom % 2 == 0) begin
            feedback_i = GEFE_INTERLOCK;
         end else begin
            feedback_i = $urandom;
            if (feedback_i == GEFE_INTERLOCK) feedback_i = ~GEFE_INTERLOCK;
         end
         @(negedge gbt_rx_clkrs);
         exp_w = (feedback_i == GEFE_INTERLOCK) ? rx_data_i : '1;
         if (pack_pins(pl_clk_o, pl_en_o, pl_dir_o, pl_boost_o) !== exp_w)
            report_mismatch("interlock", exp_w,
                            pack_pins(pl_clk_o, pl_en_o, pl_dir_o, pl_boost_o));
      end
      end_test("interlock");

      // status synchronizer and motor pages
      for (int i = 0; i < N_STATUS; i++) begin
         pl_pfail_i   = 16'($urandom);
         pl_sw_outa_i = 16'($urandom);
         pl_sw_outb_i = 16'($urandom);
         repeat (4) @(negedge gbt_rx_clkrs);
         exp_w = expected_status(pl_pfail_i, pl_sw_outa_i, pl_sw_outb_i);
         if (motor_data_o !== exp_w) report_mismatch("status", exp_w, motor_data_o);
         for (int m = 0; m < NUM_MOTORS; m++) begin
            read_page(PAGE_MOTOR_BASE + 8'(m), w);
            if (w !== 32'(exp_w[m*MOTOR_BITS +: MOTOR_BITS]))
               report_mismatch("status page", 64'(exp_w[m*MOTOR_BITS +: MOTOR_BITS]), 64'(w));
         end
      end
      end_test("status");

      // processor transfers with shadow hold
      for (int k = 0; k < N_TRANSFER; k++) begin
         for (int a = 0; a < BUF_DEPTH; a++) begin
            n = int'($urandom % 8);
            if (n < 6) begin
               id = known_ids[n];
            end else begin
               id = 8'($urandom);
               if (is_known_id(id)) id = 8'hff;
            end
            buf_mem[a] = {id, 8'($urandom), 16'($urandom)};
         end
         @(negedge gbt_rx_clkrs);
         ps_req_i = 1'b1;
         n = 0;
         while (!ps_ack_o && n < ACK_LIMIT) begin
            @(negedge gbt_rx_clkrs);
            n++;
         end
         if (!ps_ack_o) report_failure("transfer: acknowledge did not rise after the request");
         repeat (BUF_DEPTH + 4) @(negedge gbt_rx_clkrs);
         if (ps_ack_o !== 1'b1) report_failure("transfer: acknowledge dropped while requested");
         // values from before this transfer
         check_diag_pages("shadow_hold");
         ps_req_i = 1'b0;
         n = 0;
         while (ps_ack_o && n < ACK_LIMIT) begin
            @(negedge gbt_rx_clkrs);
            n++;
         end
         if (ps_ack_o) report_failure("transfer: acknowledge did not fall after release");
         // one edge for the shadow copy
         @(negedge gbt_rx_clkrs);
         apply_entries();
         check_diag_pages("transfer");
      end
      end_test("transfer");

      // readback pages
      sel           = $urandom;
      // bit 31 high makes the loopback word differ from its reset value
      sel[31]       = 1'b1;
      page_select_i = sel;
      page_update_i = 1'b1;
      @(negedge gbt_rx_clkrs);
      page_update_i = 1'b0;
      read_page(PAGE_LOOPBACK, w);
      if (w !== {sel[31], 30'b0, 1'b1})
         report_mismatch("loopback", 64'({sel[31], 30'b0, 1'b1}), 64'(w));
      read_page(PAGE_BUILD, w);
      if (w !== BUILD_NUMBER) report_mismatch("build", 64'(BUILD_NUMBER), 64'(w));
      pcbrev_i = 4'($urandom);
      read_page(PAGE_PCBREV, w);
      if (w !== 32'(pcbrev_i)) report_mismatch("pcbrev", 64'(pcbrev_i), 64'(w));
      read_page(PAGE_ONE, w);
      if (w !== 32'd1) report_mismatch("page_one", 64'd1, 64'(w));
      p = 8'($urandom);
      while (p < 8'd8 || (p >= 8'd16 && p < 8'd32)) p = 8'($urandom);
      read_page(p, w);
      if (w !== READBACK_DEFAULT) report_mismatch("unknown page", 64'(READBACK_DEFAULT), 64'(w));
      // page moves while the link enable is low
      read_page(PAGE_BUILD, w);
      page_select_i = {24'($urandom), PAGE_ONE};
      rx_clken_i    = 1'b0;
      repeat (3) @(negedge gbt_rx_clkrs);
      if (readback_o !== BUILD_NUMBER)
         report_mismatch("clken hold", 64'(BUILD_NUMBER), 64'(readback_o));
      end_test("readback");

      $display("tests run %0d, tests failed %0d, errors %0d", tests_done, tests_failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: build.f
src/mcoi_app_pkg.sv
src/ps_buffer_reader.sv
src/ps_register_file.sv
src/motor_interlock.sv
src/status_synchronizer.sv
src/readback_mux.sv
src/mcoi_app_top.sv
verification/tb_mcoi_app.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and searches the log for the pass line
set -u

cd "$(dirname "$0")"
LOG=sim.log

if ! verilator --binary --timing --top-module tb_mcoi_app -f build.f -o sim_tb; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/sim_tb > "$LOG" 2>&1; then
   cat "$LOG"
   echo "simulation exited with an error status"
   exit 1
fi

cat "$LOG"

if grep -q -x "PASS: all tests" "$LOG"; then
   exit 0
fi
echo "pass line not found in $LOG"
exit 1
